/* proc_pkg.sv */
`default_nettype none

package proc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [4:0] {
        OP_RTYPE = 5'd0,
        OP_J     = 5'd1,
        OP_BNE   = 5'd2,
        OP_JAL   = 5'd3,
        OP_JR    = 5'd4,
        OP_ADDI  = 5'd5,
        OP_BLT   = 5'd6,
        OP_SW    = 5'd7,
        OP_LW    = 5'd8
    } opcode_t;

    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_t;

    // Instruction field positions
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 27;
    localparam int RD_MSB     = 26;
    localparam int RD_LSB     = 22;
    localparam int RS_MSB     = 21;
    localparam int RS_LSB     = 17;
    localparam int RT_MSB     = 16;
    localparam int RT_LSB     = 12;
    localparam int SHAMT_MSB  = 11;
    localparam int SHAMT_LSB  = 7;
    localparam int ALUOP_MSB  = 6;
    localparam int ALUOP_LSB  = 2;
    localparam int IMM_MSB    = 16; // Immediate is [16:0], signed
    localparam int TARGET_MSB = 26; // Target is [26:0], unsigned

    localparam reg_idx_t REG_ZERO = 5'd0;
    localparam reg_idx_t REG_LINK = 5'd31; // jal destination

    // add r0, r0, r0
    localparam word_t NOP_INST = 32'h0000_0000;

    function automatic opcode_t inst_opcode(input word_t inst);
        return opcode_t'(inst[OPCODE_MSB:OPCODE_LSB]);
    endfunction

    function automatic word_t sign_ext_imm(input word_t inst);
        return {{(31 - IMM_MSB){inst[IMM_MSB]}}, inst[IMM_MSB:0]};
    endfunction

endpackage

`default_nettype wire

/* alu.sv */
`default_nettype none

module alu (
    input  proc_pkg::word_t   operand_a,
    input  proc_pkg::word_t   operand_b,
    input  proc_pkg::alu_op_t op,
    input  logic [4:0]        shamt,
    output proc_pkg::word_t   result,
    output logic              not_equal,
    output logic              less_than
);
    import proc_pkg::*;

    word_t sum;
    word_t diff;
    logic  sub_overflow;

    assign sum  = operand_a + operand_b;
    assign diff = operand_a - operand_b;

    // Signed overflow of a - b
    assign sub_overflow = (operand_a[31] != operand_b[31]) && (diff[31] != operand_a[31]);

    // Flags come from the subtractor whatever op is selected
    assign not_equal = |diff;
    assign less_than = diff[31] ^ sub_overflow;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = sum;
            end
            ALU_SUB: begin
                result = diff;
            end
            ALU_AND: begin
                result = operand_a & operand_b;
            end
            ALU_OR: begin
                result = operand_a | operand_b;
            end
            ALU_SLL: begin
                result = operand_a << shamt;
            end
            ALU_SRA: begin
                result = $signed(operand_a) >>> shamt;
            end
            default: begin
                result = '0; // Unused aluop codes
            end
        endcase
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`default_nettype none

module fetch_unit (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            redirect,
    input  proc_pkg::word_t redirect_pc,
    input  proc_pkg::word_t q_imem,
    output proc_pkg::word_t address_imem,
    output proc_pkg::word_t fd_inst,
    output proc_pkg::word_t fd_pc_plus_one
);
    import proc_pkg::*;

    word_t pc;
    word_t pc_plus_one;
    word_t next_pc;

    assign pc_plus_one  = pc + 32'd1;
    assign next_pc      = redirect ? redirect_pc : pc_plus_one; // Taken branch or jump wins
    assign address_imem = pc;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            fd_inst <= NOP_INST;
        end else begin
            pc      <= next_pc;
            fd_inst <= redirect ? NOP_INST : q_imem; // Squash the wrong-path fetch
        end
    end

    // Successor address travels with the instruction
    always_ff @(posedge clock) begin
        fd_pc_plus_one <= pc_plus_one;
    end

endmodule

`default_nettype wire

/* decode_stage.sv */
`default_nettype none

module decode_stage (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               redirect,
    input  proc_pkg::word_t    fd_inst,
    input  proc_pkg::word_t    fd_pc_plus_one,
    output proc_pkg::reg_idx_t ctrl_readRegA,
    output proc_pkg::reg_idx_t ctrl_readRegB,
    input  proc_pkg::word_t    data_readRegA,
    input  proc_pkg::word_t    data_readRegB,
    input  logic               wb_enable,
    input  proc_pkg::reg_idx_t wb_reg,
    input  proc_pkg::word_t    wb_data,
    output proc_pkg::word_t    de_inst,
    output proc_pkg::word_t    de_pc_plus_one,
    output proc_pkg::word_t    de_reg_a,
    output proc_pkg::word_t    de_reg_b,
    output proc_pkg::reg_idx_t de_read_a,
    output proc_pkg::reg_idx_t de_read_b,
    output proc_pkg::reg_idx_t de_write_reg
);
    import proc_pkg::*;

    opcode_t  op;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    logic     reads_rd;
    logic     no_dest;
    reg_idx_t write_reg;
    word_t    corr_a;
    word_t    corr_b;

    assign op = inst_opcode(fd_inst);
    assign rd = fd_inst[RD_MSB:RD_LSB];
    assign rs = fd_inst[RS_MSB:RS_LSB];
    assign rt = fd_inst[RT_MSB:RT_LSB];

    // Compares, jr and sw take their second operand from rd
    assign reads_rd = (op == OP_BNE) || (op == OP_BLT) || (op == OP_JR) || (op == OP_SW);

    assign ctrl_readRegA = rs;

    always_comb begin
        if (reads_rd) begin
            ctrl_readRegB = rd;
        end else if (op == OP_LW) begin
            ctrl_readRegB = rs;
        end else begin
            ctrl_readRegB = rt;
        end
    end

    // Stores, branches and jumps leave the register file alone
    assign no_dest   = (op == OP_SW) || (op == OP_BNE) || (op == OP_BLT) ||
                       (op == OP_J) || (op == OP_JR);
    assign write_reg = no_dest ? REG_ZERO : rd;

    // Register file is written at the end of this cycle, so pick up the value now
    assign corr_a = (wb_enable && wb_reg == ctrl_readRegA) ? wb_data : data_readRegA;
    assign corr_b = (wb_enable && wb_reg == ctrl_readRegB) ? wb_data : data_readRegB;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            de_inst      <= NOP_INST;
            de_read_a    <= REG_ZERO;
            de_read_b    <= REG_ZERO;
            de_write_reg <= REG_ZERO;
        end else begin
            de_inst      <= redirect ? NOP_INST : fd_inst;
            de_read_a    <= ctrl_readRegA;
            de_read_b    <= ctrl_readRegB;
            de_write_reg <= redirect ? REG_ZERO : write_reg; // Flushed slot writes nothing
        end
    end

    always_ff @(posedge clock) begin
        de_pc_plus_one <= fd_pc_plus_one;
        de_reg_a       <= corr_a;
        de_reg_b       <= corr_b;
    end

endmodule

`default_nettype wire

/* execute_stage.sv */
`default_nettype none

module execute_stage (
    input  logic               clock,
    input  logic               rst_n,
    input  proc_pkg::word_t    de_inst,
    input  proc_pkg::word_t    de_pc_plus_one,
    input  proc_pkg::word_t    de_reg_a,
    input  proc_pkg::word_t    de_reg_b,
    input  proc_pkg::reg_idx_t de_read_a,
    input  proc_pkg::reg_idx_t de_read_b,
    input  proc_pkg::reg_idx_t de_write_reg,
    input  proc_pkg::word_t    mem_fwd_data,
    input  proc_pkg::word_t    wb_data,
    input  logic               wb_enable,
    input  proc_pkg::reg_idx_t wb_reg,
    output logic               redirect,
    output proc_pkg::word_t    redirect_pc,
    output proc_pkg::word_t    em_inst,
    output proc_pkg::word_t    em_result,
    output proc_pkg::word_t    em_store_data,
    output proc_pkg::reg_idx_t em_write_reg,
    output logic               em_writes
);
    import proc_pkg::*;

    opcode_t  op;
    logic     is_bne;
    logic     is_blt;
    logic     is_j;
    logic     is_jal;
    logic     is_jr;
    logic     use_imm;
    logic     branch_taken;
    word_t    imm_ext;
    word_t    fwd_a;
    word_t    fwd_b;
    word_t    operand_sel;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    word_t    branch_target;
    alu_op_t  alu_op;
    logic     not_equal;
    logic     less_than;
    reg_idx_t write_reg;
    logic     writes;

    // Youngest producer first, then the one in writeback
    function automatic word_t forward(input reg_idx_t idx, input word_t reg_val);
        if (em_writes && em_write_reg == idx) begin
            return mem_fwd_data;
        end else if (wb_enable && wb_reg == idx) begin
            return wb_data;
        end
        return reg_val;
    endfunction

    assign op      = inst_opcode(de_inst);
    assign is_bne  = (op == OP_BNE);
    assign is_blt  = (op == OP_BLT);
    assign is_j    = (op == OP_J);
    assign is_jal  = (op == OP_JAL);
    assign is_jr   = (op == OP_JR);
    assign use_imm = (op == OP_ADDI) || (op == OP_LW) || (op == OP_SW);
    assign imm_ext = sign_ext_imm(de_inst);

    always_comb begin
        fwd_a = forward(de_read_a, de_reg_a);
        fwd_b = forward(de_read_b, de_reg_b);
    end

    assign operand_sel = use_imm ? imm_ext : fwd_b;

    // blt tests rd < rs, so rd goes on the A side
    assign alu_a = is_blt ? operand_sel : fwd_a;
    assign alu_b = is_blt ? fwd_a : operand_sel;

    always_comb begin
        if (op == OP_RTYPE) begin
            alu_op = alu_op_t'(de_inst[ALUOP_MSB:ALUOP_LSB]);
        end else if (is_bne || is_blt) begin
            alu_op = ALU_SUB;
        end else begin
            alu_op = ALU_ADD; // addi and address calculation
        end
    end

    alu u_alu (
        .operand_a (alu_a),
        .operand_b (alu_b),
        .op        (alu_op),
        .shamt     (de_inst[SHAMT_MSB:SHAMT_LSB]),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    assign branch_taken  = (is_bne && not_equal) || (is_blt && less_than);
    assign branch_target = de_pc_plus_one + imm_ext;
    assign redirect      = is_j || is_jal || is_jr || branch_taken;

    always_comb begin
        if (is_jr) begin
            redirect_pc = fwd_b; // Forwarded rd
        end else if (is_j || is_jal) begin
            redirect_pc = {{(31 - TARGET_MSB){1'b0}}, de_inst[TARGET_MSB:0]};
        end else begin
            redirect_pc = branch_target;
        end
    end

    assign write_reg = is_jal ? REG_LINK : de_write_reg;
    assign writes    = ((op == OP_RTYPE) || (op == OP_ADDI) || (op == OP_LW) || is_jal) &&
                       (write_reg != REG_ZERO);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            em_inst      <= NOP_INST;
            em_write_reg <= REG_ZERO;
            em_writes    <= 1'b0;
        end else begin
            em_inst      <= de_inst;
            em_write_reg <= write_reg;
            em_writes    <= writes;
        end
    end

    always_ff @(posedge clock) begin
        em_result     <= is_jal ? de_pc_plus_one : alu_result; // Link value for jal
        em_store_data <= fwd_b;
    end

endmodule

`default_nettype wire

/* result_stage.sv */
`default_nettype none

module result_stage (
    input  logic               clock,
    input  logic               rst_n,
    input  proc_pkg::word_t    em_inst,
    input  proc_pkg::word_t    em_result,
    input  proc_pkg::word_t    em_store_data,
    input  proc_pkg::reg_idx_t em_write_reg,
    input  logic               em_writes,
    output proc_pkg::word_t    address_dmem,
    output proc_pkg::word_t    data,
    output logic               wren,
    input  proc_pkg::word_t    q_dmem,
    output proc_pkg::word_t    mem_fwd_data,
    output logic               ctrl_writeEnable,
    output proc_pkg::reg_idx_t ctrl_writeReg,
    output proc_pkg::word_t    data_writeReg
);
    import proc_pkg::*;

    opcode_t op;

    assign op = inst_opcode(em_inst);

    // ALU result is the address for both lw and sw
    assign address_dmem = em_result;
    assign data         = em_store_data;
    assign wren         = (op == OP_SW);

    // Read data is combinational, so a load forwards in the same cycle
    assign mem_fwd_data = (op == OP_LW) ? q_dmem : em_result;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_writeEnable <= 1'b0;
            ctrl_writeReg    <= REG_ZERO;
        end else begin
            ctrl_writeEnable <= em_writes;
            ctrl_writeReg    <= em_write_reg;
        end
    end

    always_ff @(posedge clock) begin
        data_writeReg <= mem_fwd_data;
    end

endmodule

`default_nettype wire

/* processor.sv */
`default_nettype none

module processor (
    input  logic               clock,
    input  logic               rst_n,
    output proc_pkg::word_t    address_imem,
    input  proc_pkg::word_t    q_imem,
    output proc_pkg::word_t    address_dmem,
    output proc_pkg::word_t    data,
    output logic               wren,
    input  proc_pkg::word_t    q_dmem,
    output logic               ctrl_writeEnable,
    output proc_pkg::reg_idx_t ctrl_writeReg,
    output proc_pkg::reg_idx_t ctrl_readRegA,
    output proc_pkg::reg_idx_t ctrl_readRegB,
    output proc_pkg::word_t    data_writeReg,
    input  proc_pkg::word_t    data_readRegA,
    input  proc_pkg::word_t    data_readRegB
);
    import proc_pkg::*;

    logic     redirect;
    word_t    redirect_pc;
    word_t    fd_inst;
    word_t    fd_pc_plus_one;
    word_t    de_inst;
    word_t    de_pc_plus_one;
    word_t    de_reg_a;
    word_t    de_reg_b;
    reg_idx_t de_read_a;
    reg_idx_t de_read_b;
    reg_idx_t de_write_reg;
    word_t    em_inst;
    word_t    em_result;
    word_t    em_store_data;
    reg_idx_t em_write_reg;
    logic     em_writes;
    word_t    mem_fwd_data;

    fetch_unit u_fetch (
        .clock          (clock),
        .rst_n          (rst_n),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .q_imem         (q_imem),
        .address_imem   (address_imem),
        .fd_inst        (fd_inst),
        .fd_pc_plus_one (fd_pc_plus_one)
    );

    // Writeback port doubles as the write-through source
    decode_stage u_decode (
        .clock          (clock),
        .rst_n          (rst_n),
        .redirect       (redirect),
        .fd_inst        (fd_inst),
        .fd_pc_plus_one (fd_pc_plus_one),
        .ctrl_readRegA  (ctrl_readRegA),
        .ctrl_readRegB  (ctrl_readRegB),
        .data_readRegA  (data_readRegA),
        .data_readRegB  (data_readRegB),
        .wb_enable      (ctrl_writeEnable),
        .wb_reg         (ctrl_writeReg),
        .wb_data        (data_writeReg),
        .de_inst        (de_inst),
        .de_pc_plus_one (de_pc_plus_one),
        .de_reg_a       (de_reg_a),
        .de_reg_b       (de_reg_b),
        .de_read_a      (de_read_a),
        .de_read_b      (de_read_b),
        .de_write_reg   (de_write_reg)
    );

    execute_stage u_execute (
        .clock          (clock),
        .rst_n          (rst_n),
        .de_inst        (de_inst),
        .de_pc_plus_one (de_pc_plus_one),
        .de_reg_a       (de_reg_a),
        .de_reg_b       (de_reg_b),
        .de_read_a      (de_read_a),
        .de_read_b      (de_read_b),
        .de_write_reg   (de_write_reg),
        .mem_fwd_data   (mem_fwd_data),
        .wb_data        (data_writeReg),
        .wb_enable      (ctrl_writeEnable),
        .wb_reg         (ctrl_writeReg),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .em_inst        (em_inst),
        .em_result      (em_result),
        .em_store_data  (em_store_data),
        .em_write_reg   (em_write_reg),
        .em_writes      (em_writes)
    );

    result_stage u_result (
        .clock            (clock),
        .rst_n            (rst_n),
        .em_inst          (em_inst),
        .em_result        (em_result),
        .em_store_data    (em_store_data),
        .em_write_reg     (em_write_reg),
        .em_writes        (em_writes),
        .address_dmem     (address_dmem),
        .data             (data),
        .wren             (wren),
        .q_dmem           (q_dmem),
        .mem_fwd_data     (mem_fwd_data),
        .ctrl_writeEnable (ctrl_writeEnable),
        .ctrl_writeReg    (ctrl_writeReg),
        .data_writeReg    (data_writeReg)
    );

endmodule

`default_nettype wire

/* processor_assertions.sv */
`default_nettype none

module processor_assertions (
    input logic               clock,
    input logic               rst_n,
    input logic               wren,
    input logic               ctrl_writeEnable,
    input proc_pkg::reg_idx_t ctrl_writeReg
);
    import proc_pkg::*;

    int failures = 0; // Failed assertions so far

    no_zero_write: assert property (@(posedge clock) disable iff (!rst_n)
        ctrl_writeEnable |-> ctrl_writeReg != REG_ZERO)
        else begin
            $error("Register write strobe aimed at register 0");
            failures++;
        end

    strobes_apart: assert property (@(posedge clock) disable iff (!rst_n)
        !(wren && ctrl_writeEnable))
        else begin
            $error("Store and register write strobes high in the same cycle");
            failures++;
        end

    // First cycle out of reset
    quiet_after_reset: assert property (@(posedge clock)
        $rose(rst_n) |-> !wren && !ctrl_writeEnable)
        else begin
            $error("Strobe active in the first cycle after reset");
            failures++;
        end

endmodule

bind processor processor_assertions u_assertions (
    .clock            (clock),
    .rst_n            (rst_n),
    .wren             (wren),
    .ctrl_writeEnable (ctrl_writeEnable),
    .ctrl_writeReg    (ctrl_writeReg)
);

`default_nettype wire

/* tb_processor.sv */
`default_nettype none

module tb_processor;
    import proc_pkg::*;

    localparam int NUM_TESTS = 5;

    logic     clock;
    logic     rst_n;
    word_t    address_imem;
    word_t    q_imem;
    word_t    address_dmem;
    word_t    data;
    logic     wren;
    word_t    q_dmem;
    logic     ctrl_writeEnable;
    reg_idx_t ctrl_writeReg;
    reg_idx_t ctrl_readRegA;
    reg_idx_t ctrl_readRegB;
    word_t    data_writeReg;
    word_t    data_readRegA;
    word_t    data_readRegB;

    word_t    imem [0:63];
    word_t    dmem [0:255];
    word_t    rf [0:31];
    int       prog_len;
    word_t    halt_addr;
    int       cyc;
    int       total_cycles;
    int       cycle_limit = 20 * NUM_TESTS; // Program lengths are added as they load
    reg_idx_t wb_regs [$];
    word_t    wb_vals [$];
    int       wb_cycles [$];
    word_t    st_addrs [$];
    word_t    st_vals [$];
    int       st_cycles [$];

    processor dut (.*);

    // Memories and register file, all reads combinational
    assign q_imem        = imem[address_imem[5:0]];
    assign q_dmem        = dmem[address_dmem[7:0]];
    assign data_readRegA = rf[ctrl_readRegA];
    assign data_readRegB = rf[ctrl_readRegB];

    always @(posedge clock) begin
        if (ctrl_writeEnable && ctrl_writeReg != REG_ZERO) begin
            rf[ctrl_writeReg] <= data_writeReg;
        end
        if (wren) begin
            dmem[address_dmem[7:0]] <= data;
        end
    end

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cyc          <= rst_n ? cyc + 1 : 0; // Cycle 0 is the first fetch after reset
        total_cycles <= total_cycles + 1;
        if (total_cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the final jump was never fetched", total_cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // Log of writeback and store strobes, sampled mid-cycle
    always @(negedge clock) begin
        if (rst_n && ctrl_writeEnable) begin
            wb_regs.push_back(ctrl_writeReg);
            wb_vals.push_back(data_writeReg);
            wb_cycles.push_back(cyc);
        end
        if (rst_n && wren) begin
            st_addrs.push_back(address_dmem);
            st_vals.push_back(data);
            st_cycles.push_back(cyc);
        end
    end

    task automatic stop_on_error(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            stop_on_error($sformatf("%s expected %h got %h", what, expected, got));
        end
    endtask

    task automatic check_reg(input string what, input reg_idx_t got, input reg_idx_t expected);
        if (got !== expected) begin
            stop_on_error($sformatf("%s expected r%0d got r%0d", what, expected, got));
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            stop_on_error($sformatf("%s expected %b got %b", what, expected, got));
        end
    endtask

    function automatic word_t rtype_word(input alu_op_t f, input reg_idx_t rd,
                                         input reg_idx_t rs, input reg_idx_t rt,
                                         input logic [4:0] sh);
        return {OP_RTYPE, rd, rs, rt, sh, f, 2'b00};
    endfunction

    function automatic word_t itype_word(input opcode_t op, input reg_idx_t rd,
                                         input reg_idx_t rs, input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic word_t jtype_word(input opcode_t op, input logic [26:0] target);
        return {op, target};
    endfunction

    function automatic word_t widen_imm(input logic [16:0] imm);
        return {{15{imm[16]}}, imm};
    endfunction

    function automatic logic [16:0] random_imm();
        return 17'($urandom);
    endfunction

    task automatic clear_memories;
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP_INST;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] <= word_t'(i) * 32'h9e37_79b1 + 32'h0000_5a3c;
        end
        for (int i = 0; i < 32; i++) begin
            rf[i] <= '0;
        end
    endtask

    task automatic begin_program;
        @(posedge clock);
        rst_n <= 1'b0;
        clear_memories();
        prog_len = 0;
        wb_regs.delete();
        wb_vals.delete();
        wb_cycles.delete();
        st_addrs.delete();
        st_vals.delete();
        st_cycles.delete();
    endtask

    task automatic place(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // Program ends in a jump to itself
    task automatic finish_program;
        halt_addr = word_t'(prog_len);
        place(jtype_word(OP_J, 27'(prog_len)));
        cycle_limit += prog_len;
    endtask

    task automatic release_reset;
        repeat (5) @(posedge clock);
        rst_n <= 1'b1;
    endtask

    task automatic run_to_halt;
        do begin
            @(negedge clock);
        end while (address_imem !== halt_addr);
        repeat (5) @(negedge clock); // Drain the older instructions
    endtask

    task automatic expect_write(input int n, input reg_idx_t r, input word_t v);
        check_reg($sformatf("write %0d register", n), wb_regs[n], r);
        check_word($sformatf("write %0d value", n), wb_vals[n], v);
    endtask

    // Read indices of the instruction in decode during cycle at
    task automatic expect_reads(input int at, input reg_idx_t a, input reg_idx_t b);
        while (cyc != at) begin
            @(negedge clock);
        end
        check_reg($sformatf("read A in cycle %0d", at), ctrl_readRegA, a);
        check_reg($sformatf("read B in cycle %0d", at), ctrl_readRegB, b);
    endtask

    task automatic reset_state_test;
        begin_program();
        for (int i = 0; i < 6; i++) begin
            place(NOP_INST);
        end
        finish_program();
        @(negedge clock);
        check_word("fetch address in reset", address_imem, 32'd0);
        check_bit("wren in reset", wren, 1'b0);
        check_bit("write enable in reset", ctrl_writeEnable, 1'b0);
        check_bit("redirect in reset", dut.redirect, 1'b0);
        release_reset();
        for (int i = 0; i < 6; i++) begin
            @(negedge clock);
            check_word("fetch address after reset", address_imem, word_t'(i));
        end
        run_to_halt();
    endtask

    task automatic alu_forwarding_test;
        logic [16:0] i1;
        logic [16:0] i2;
        logic [4:0]  s1;
        logic [4:0]  s2;
        word_t       exp_r [1:9];
        begin_program();
        i1 = random_imm();
        i2 = random_imm();
        s1 = 5'($urandom);
        s2 = 5'($urandom);
        exp_r[1] = widen_imm(i1);
        exp_r[2] = exp_r[1] + widen_imm(i2);
        exp_r[3] = exp_r[1] + exp_r[2];
        exp_r[4] = exp_r[3] - exp_r[1];
        exp_r[5] = exp_r[4] & exp_r[2];
        exp_r[6] = exp_r[5] | exp_r[3];
        exp_r[7] = exp_r[6] << s1;
        exp_r[8] = $signed(exp_r[7]) >>> s2;
        exp_r[9] = exp_r[8] + exp_r[8];
        place(itype_word(OP_ADDI, 1, 0, i1));
        place(itype_word(OP_ADDI, 2, 1, i2)); // r1 from the memory stage
        place(rtype_word(ALU_ADD, 3, 1, 2, 5'd0));
        place(rtype_word(ALU_SUB, 4, 3, 1, 5'd0)); // r1 by write-through
        place(rtype_word(ALU_AND, 5, 4, 2, 5'd0));
        place(rtype_word(ALU_OR, 6, 5, 3, 5'd0));
        place(rtype_word(ALU_SLL, 7, 6, 0, s1));
        place(rtype_word(ALU_SRA, 8, 7, 0, s2));
        place(rtype_word(ALU_ADD, 9, 8, 8, 5'd0));
        finish_program();
        release_reset();
        run_to_halt();
        check_word("ALU write count", word_t'(wb_vals.size()), 32'd9);
        for (int i = 0; i < 9; i++) begin
            expect_write(i, reg_idx_t'(i + 1), exp_r[i + 1]);
            check_word("writeback cycle", word_t'(wb_cycles[i]), word_t'(i + 4));
        end
    endtask

    task automatic memory_test;
        logic [16:0] base;
        logic [16:0] off;
        logic [16:0] val;
        word_t       addr;
        begin_program();
        base = 17'(100 + $urandom % 32);
        off  = 17'($urandom % 64) - 17'd32;
        val  = random_imm();
        addr = widen_imm(base) + widen_imm(off);
        place(itype_word(OP_ADDI, 1, 0, base));
        place(itype_word(OP_ADDI, 2, 0, val));
        place(NOP_INST); // Keeps the store clear of a writeback
        place(itype_word(OP_SW, 2, 1, off));
        place(itype_word(OP_LW, 3, 1, off));
        place(rtype_word(ALU_ADD, 4, 3, 2, 5'd0)); // Load result forwarded
        finish_program();
        release_reset();
        expect_reads(4, 1, 2); // sw reads rd on port B
        expect_reads(5, 1, 1); // lw reads rs on both ports
        expect_reads(6, 3, 2);
        run_to_halt();
        check_word("store count", word_t'(st_addrs.size()), 32'd1);
        check_word("store address", st_addrs[0], addr);
        check_word("store data", st_vals[0], widen_imm(val));
        check_word("store cycle", word_t'(st_cycles[0]), 32'd6);
        check_word("memory word", dmem[addr[7:0]], widen_imm(val));
        check_word("loaded r3", rf[3], widen_imm(val));
        check_word("sum after load", rf[4], widen_imm(val) + widen_imm(val));
    endtask

    task automatic branch_test;
        logic [16:0] a;
        logic [16:0] d;
        begin_program();
        a = random_imm();
        d = 17'(1 + $urandom % 1000); // r2 is always above r1
        place(itype_word(OP_ADDI, 1, 0, a));
        place(itype_word(OP_ADDI, 2, 1, d));
        place(itype_word(OP_BNE, 1, 2, 17'd2)); // Taken to 5
        place(itype_word(OP_ADDI, 10, 0, 17'd1));
        place(itype_word(OP_ADDI, 11, 0, 17'd1));
        place(itype_word(OP_ADDI, 12, 0, 17'd12));
        place(itype_word(OP_BNE, 1, 1, 17'd2)); // Falls through
        place(itype_word(OP_ADDI, 13, 0, 17'd13));
        place(itype_word(OP_ADDI, 14, 0, 17'd14));
        place(itype_word(OP_BLT, 1, 2, 17'd2)); // Taken to 12
        place(itype_word(OP_ADDI, 15, 0, 17'd1));
        place(itype_word(OP_ADDI, 16, 0, 17'd1));
        place(itype_word(OP_ADDI, 17, 0, 17'd17));
        place(itype_word(OP_BLT, 2, 1, 17'd2)); // Falls through
        place(itype_word(OP_ADDI, 18, 0, 17'd18));
        place(itype_word(OP_ADDI, 19, 0, 17'd19));
        finish_program();
        release_reset();
        run_to_halt();
        check_word("branch write count", word_t'(wb_vals.size()), 32'd8);
        check_word("r2 before branches", rf[2], widen_imm(a) + widen_imm(d));
        for (int r = 10; r <= 19; r++) begin
            check_word($sformatf("r%0d after branches", r), rf[r],
                       (r == 10 || r == 11 || r == 15 || r == 16) ? 32'd0 : word_t'(r));
        end
    endtask

    task automatic jump_test;
        logic [16:0] v;
        begin_program();
        v = random_imm();
        place(jtype_word(OP_J, 27'd3));
        place(itype_word(OP_ADDI, 10, 0, 17'd1));
        place(itype_word(OP_ADDI, 11, 0, 17'd1));
        place(itype_word(OP_ADDI, 12, 0, 17'd12));
        place(jtype_word(OP_JAL, 27'd8));
        place(itype_word(OP_ADDI, 13, 0, v)); // Return point
        place(jtype_word(OP_J, 27'd12));
        place(itype_word(OP_ADDI, 14, 0, 17'd1));
        place(itype_word(OP_ADDI, 21, 31, 17'd0));
        place(itype_word(OP_JR, 21, 0, 17'd0)); // r21 still in the memory stage
        place(itype_word(OP_ADDI, 15, 0, 17'd1));
        place(itype_word(OP_ADDI, 16, 0, 17'd1));
        finish_program();
        release_reset();
        run_to_halt();
        check_word("jump write count", word_t'(wb_vals.size()), 32'd4);
        expect_write(0, 12, 32'd12);
        expect_write(1, REG_LINK, 32'd5); // jal at 4
        expect_write(2, 21, 32'd5);
        expect_write(3, 13, widen_imm(v));
    endtask

    initial begin
        rst_n = 1'b0;
        void'($urandom(32'h4457_8aa2));
        clear_memories();
        reset_state_test();
        alu_forwarding_test();
        memory_test();
        branch_test();
        jump_test();
        if (dut.u_assertions.failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
proc_pkg.sv
alu.sv
fetch_unit.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
processor.sv
processor_assertions.sv
tb_processor.sv
